// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP ?= shader_front_tb
RTL_TOP ?= shader_front
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TB_TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/class_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module class_dispatch (
	input  logic                        clk,
	input  logic                        rst_n,
	input  shader_front_pkg::wave_t     wave,
	output shader_front_pkg::dispatch_t dispatch,
	output shader_front_pkg::group_id_t out_group,
	output shader_front_pkg::insn_t     held_insn,
	output logic                        writeback
);

	logic hold_valid;
	logic hold_retry;
	logic is_mem;
	logic is_sfu;
	logic is_group;
	logic port_ok;
	shader_front_pkg::group_id_t hold_group;

	assign port_ok = hold_valid & ~hold_retry;
	assign writeback = port_ok & ~(is_mem | is_sfu | is_group); // The fpint port has no strobe.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_valid <= 1'b0;
			hold_retry <= 1'b0;
			is_mem <= 1'b0;
			is_sfu <= 1'b0;
			is_group <= 1'b0;
			dispatch <= '0;
		end else begin
			hold_valid <= wave.valid;
			hold_retry <= wave.retry;
			is_mem <= 1'b0;
			is_sfu <= 1'b0;
			is_group <= 1'b0;
			case (wave.insn.insn_class)
				shader_front_pkg::INSN_MEM:   is_mem <= 1'b1;
				shader_front_pkg::INSN_SFU:   is_sfu <= 1'b1;
				shader_front_pkg::INSN_GROUP: is_group <= 1'b1;
				default: ;
			endcase

			dispatch.valid <= hold_valid; // A retry still dispatches, with no port.
			dispatch.p1_mem <= port_ok & is_mem;
			dispatch.p2_sfu <= port_ok & is_sfu;
			dispatch.p3_group <= port_ok & is_group;
		end
	end

	always_ff @(posedge clk) begin
		hold_group <= wave.group;
		held_insn <= wave.insn;
		out_group <= hold_group;
	end

endmodule

`default_nettype wire

// ==== logic/fpint_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpint_decode (
	input  logic                        clk,
	input  shader_front_pkg::insn_t     insn,
	input  logic                        writeback,
	output shader_front_pkg::fpint_op_t op
);

	shader_front_pkg::fpint_op_t flags;

	always_comb begin
		// The mov row serves as the base; other opcodes override a few flags.
		flags.setup_mul_float = 1'b0;
		flags.setup_unit_b = 1'b1;
		flags.mnorm_put_hi = 1'b0;
		flags.mnorm_put_lo = 1'b1;
		flags.mnorm_put_mul = 1'b0;
		flags.mnorm_zero_flags = 1'b1;
		flags.mnorm_zero_b = 1'b1;
		flags.minmax_abs = 1'b1;
		flags.minmax_swap = 1'b0;
		flags.minmax_zero_min = 1'b0;
		flags.minmax_copy_flags = 1'b1;
		flags.shiftr_int_signed = 1'b0;
		flags.addsub_int_operand = 1'b0;
		flags.addsub_copy_flags = 1'b1;
		flags.clz_force_nop = 1'b1;
		flags.shiftl_copy_flags = 1'b1;
		flags.round_copy_flags = 1'b1;
		flags.round_enable = 1'b1;
		flags.encode_enable = 1'b1;
		flags.writeback = writeback;

		case (insn.fpint_op)
			shader_front_pkg::FPINT_FMUL: begin
				flags.setup_mul_float = 1'b1;
				flags.setup_unit_b = 1'b0;
				flags.mnorm_put_lo = 1'b0;
				flags.mnorm_put_mul = 1'b1;
				flags.mnorm_zero_flags = 1'b0;
			end
			shader_front_pkg::FPINT_IMUL: begin
				flags.setup_unit_b = 1'b0;
				flags.round_enable = 1'b0; // Integer result skips rounding and encoding.
				flags.encode_enable = 1'b0;
			end
			shader_front_pkg::FPINT_FADD: begin
				flags.mnorm_zero_flags = 1'b0;
				flags.mnorm_zero_b = 1'b0;
				flags.minmax_copy_flags = 1'b0;
				flags.addsub_copy_flags = 1'b0;
				flags.clz_force_nop = 1'b0;
				flags.shiftl_copy_flags = 1'b0;
				flags.round_copy_flags = 1'b0;
			end
			shader_front_pkg::FPINT_FMAX, shader_front_pkg::FPINT_FMIN: begin
				flags.mnorm_zero_flags = 1'b0;
				flags.mnorm_zero_b = 1'b0;
				flags.minmax_abs = 1'b0;
				flags.minmax_swap = insn.fpint_op == shader_front_pkg::FPINT_FMIN;
				flags.minmax_zero_min = 1'b1;
				flags.round_enable = 1'b0;
				flags.encode_enable = 1'b0;
			end
			shader_front_pkg::FPINT_FCVT: begin
				flags.minmax_copy_flags = 1'b0;
				flags.shiftr_int_signed = 1'b1;
				flags.addsub_int_operand = 1'b1;
				flags.clz_force_nop = 1'b0;
				flags.shiftl_copy_flags = 1'b0;
				flags.round_copy_flags = 1'b0;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		op <= flags;
	end

endmodule

`default_nettype wire

// ==== logic/icache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_lookup (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         icache_flush,
	input  logic                         read_valid,
	input  shader_front_pkg::pc_t        read_pc,
	input  shader_front_pkg::group_id_t  read_group,
	input  shader_front_pkg::fill_t      fill,
	input  logic                         fill_done,
	input  logic                         req_accepted,
	output logic                         miss,
	output shader_front_pkg::line_addr_t miss_line,
	output shader_front_pkg::wave_t      wave
);

	localparam int STAGES = 6;

	typedef enum logic {
		FLUSH,
		RUN
	} state_e;

	// accessed marks a request in flight, hit marks a fill already consumed.
	typedef struct packed {
		logic                                                  valid;
		logic                                                  accessed;
		logic                                                  hit;
		shader_front_pkg::tag_t                                tag;
		shader_front_pkg::word_t [shader_front_pkg::LINE_WORDS-1:0] data;
	} line_rec_t;

	state_e state;
	shader_front_pkg::line_num_t flush_ptr;
	line_rec_t cache [shader_front_pkg::NUM_LINES];
	line_rec_t rec_2;
	line_rec_t rec_3;
	logic [STAGES-1:0] valid_pipe;
	shader_front_pkg::pc_t pc_pipe [STAGES-1];
	shader_front_pkg::group_id_t group_pipe [STAGES];
	logic in_flush;
	logic flush_2;
	logic flush_3;
	logic tag_hit;
	logic in_flight;
	logic miss_3;
	logic hit_3;
	logic miss_5;
	logic retry_4;
	logic retry_5;
	logic retry_6;
	shader_front_pkg::word_t [3:0] half_4;
	shader_front_pkg::word_t [1:0] pair_5;
	shader_front_pkg::insn_t insn_6;

	assign in_flush = state == FLUSH;
	assign miss_line = pc_pipe[3].line_addr;
	assign tag_hit = rec_3.valid & (rec_3.tag == pc_pipe[2].line_addr.tag) & ~flush_3;
	assign hit_3 = valid_pipe[2] & tag_hit;

	// Misses one or two stages ahead have not reached the array yet.
	assign in_flight = (miss & (pc_pipe[3].line_addr.line == pc_pipe[2].line_addr.line)) |
		(miss_5 & (pc_pipe[4].line_addr.line == pc_pipe[2].line_addr.line));
	assign miss_3 = valid_pipe[2] & ~tag_hit & ~rec_3.accessed & (~rec_3.valid | rec_3.hit) &
		~in_flight & ~in_flush & ~flush_3;

	always_comb begin
		wave.valid = valid_pipe[STAGES-1];
		wave.retry = retry_6;
		wave.group = group_pipe[STAGES-1];
		wave.insn = insn_6;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FLUSH;
			flush_ptr <= '0;
			valid_pipe <= '0;
			flush_2 <= 1'b1;
			flush_3 <= 1'b1;
			miss <= 1'b0;
			miss_5 <= 1'b0;
		end else begin
			case (state)
				FLUSH:
					if (!icache_flush && &flush_ptr)
						state <= RUN;
				RUN:
					if (icache_flush)
						state <= FLUSH;
				default:
					state <= FLUSH;
			endcase
			flush_ptr <= icache_flush ? '0 : flush_ptr + 1'b1;
			valid_pipe <= {valid_pipe[STAGES-2:0], read_valid};
			flush_2 <= in_flush; // Records read during the walk may be stale.
			flush_3 <= flush_2;
			miss <= miss_3;
			miss_5 <= miss & req_accepted;
		end
	end

	// Later writes win, so the flush walk overrides everything.
	always_ff @(posedge clk) begin
		if (miss_3)
			cache[pc_pipe[2].line_addr.line].accessed <= 1'b1;
		if (hit_3)
			cache[pc_pipe[2].line_addr.line].hit <= 1'b1;
		if (miss && !req_accepted)
			cache[pc_pipe[3].line_addr.line].accessed <= 1'b0; // Refused, so roll back.
		if (fill_done)
			cache[fill.line].accessed <= 1'b0;
		if (fill.enable && !in_flush) begin
			cache[fill.line].valid <= 1'b1;
			cache[fill.line].hit <= 1'b0;
			cache[fill.line].tag <= fill.tag;
			cache[fill.line].data <= fill.data;
		end
		if (in_flush) begin
			cache[flush_ptr].valid <= 1'b0;
			cache[flush_ptr].accessed <= 1'b0;
			cache[flush_ptr].hit <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		pc_pipe[0] <= read_pc;
		for (int i = 1; i < STAGES - 1; i++)
			pc_pipe[i] <= pc_pipe[i-1];
		group_pipe[0] <= read_group;
		for (int i = 1; i < STAGES; i++)
			group_pipe[i] <= group_pipe[i-1];

		rec_2 <= cache[pc_pipe[0].line_addr.line];
		rec_3 <= rec_2;

		half_4 <= pc_pipe[2].word_num[2] ? rec_3.data[7:4] : rec_3.data[3:0];
		retry_4 <= ~tag_hit;
		pair_5 <= pc_pipe[3].word_num[1] ? half_4[3:2] : half_4[1:0];
		retry_5 <= retry_4;
		insn_6 <= pc_pipe[4].word_num[0] ? pair_5[1] : pair_5[0];
		retry_6 <= retry_5;
	end

endmodule

`default_nettype wire

// ==== logic/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
	parameter int PENDING_DEPTH = 8
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         miss,
	input  shader_front_pkg::line_addr_t miss_line,
	output logic                         mem_req_valid,
	input  logic                         mem_req_ready,
	output shader_front_pkg::line_addr_t mem_req_line,
	input  logic                         mem_beat_valid,
	input  shader_front_pkg::word_t      mem_beat_data,
	input  logic                         mem_beat_last,
	output logic                         mem_beat_ready,
	output logic                         req_accepted,
	output shader_front_pkg::fill_t      fill,
	output logic                         fill_done
);

	localparam int LINE_ADDR_BITS = $bits(shader_front_pkg::line_addr_t);
	localparam int LINE_WORDS = shader_front_pkg::LINE_WORDS;

	logic fifo_full;
	logic fifo_empty;
	logic beat_fire;
	logic line_end;
	logic fill_enable;
	logic [LINE_ADDR_BITS-1:0] pending_data;
	shader_front_pkg::line_addr_t pending_line;
	shader_front_pkg::line_addr_t fill_addr;
	shader_front_pkg::word_t [LINE_WORDS-1:0] line_buf;

	// A miss is taken only if the request slot frees up and the FIFO has room.
	assign req_accepted = miss & (~mem_req_valid | mem_req_ready) & ~fifo_full;
	assign mem_beat_ready = ~fifo_empty;
	assign beat_fire = mem_beat_valid & mem_beat_ready;
	assign line_end = beat_fire & mem_beat_last;
	assign pending_line = pending_data;

	always_comb begin
		fill.enable = fill_enable;
		fill.line = fill_addr.line;
		fill.tag = fill_addr.tag;
		fill.data = line_buf; // Holds still until the next line's first beat.
	end

	line_fifo #(
		.WIDTH(LINE_ADDR_BITS),
		.DEPTH(PENDING_DEPTH)
	) pending (
		.clk,
		.rst_n,
		.push(req_accepted),
		.push_data(miss_line),
		.full(fifo_full),
		.pop(line_end),
		.pop_data(pending_data),
		.empty(fifo_empty)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_req_valid <= 1'b0;
			fill_enable <= 1'b0;
			fill_done <= 1'b0;
		end else begin
			if (req_accepted)
				mem_req_valid <= 1'b1;
			else if (mem_req_ready)
				mem_req_valid <= 1'b0;
			fill_enable <= line_end;
			fill_done <= fill_enable;
		end
	end

	always_ff @(posedge clk) begin
		if (req_accepted)
			mem_req_line <= miss_line;
		if (beat_fire)
			line_buf <= {mem_beat_data, line_buf[LINE_WORDS-1:1]}; // Oldest ends in word 0.
		if (line_end)
			fill_addr <= pending_line;
	end

endmodule

`default_nettype wire

// ==== logic/line_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
	parameter int WIDTH = 27,
	parameter int DEPTH = 8 // Must be a power of two.
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	output logic             full,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             empty
);

	localparam int PTR_BITS = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_BITS:0] wr_ptr;
	logic [PTR_BITS:0] rd_ptr;

	// The extra pointer bit tells a full FIFO from an empty one.
	assign empty = wr_ptr == rd_ptr;
	assign full = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
		(wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);
	assign pop_data = mem[rd_ptr[PTR_BITS-1:0]]; // Head is visible before the pop.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full)
			mem[wr_ptr[PTR_BITS-1:0]] <= push_data;
	end

endmodule

`default_nettype wire

// ==== logic/shader_front.sv ====
`timescale 1ns/1ps
`default_nettype none

module shader_front (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         read_valid,
	input  shader_front_pkg::pc_t        read_pc,
	input  shader_front_pkg::group_id_t  read_group,
	input  logic                         icache_flush,
	output logic                         mem_req_valid,
	input  logic                         mem_req_ready,
	output shader_front_pkg::line_addr_t mem_req_line,
	input  logic                         mem_beat_valid,
	input  shader_front_pkg::word_t      mem_beat_data,
	input  logic                         mem_beat_last,
	output logic                         mem_beat_ready,
	output shader_front_pkg::dispatch_t  dispatch,
	output shader_front_pkg::group_id_t  out_group,
	output shader_front_pkg::fpint_op_t  fpint_op
);

	localparam int PENDING_DEPTH = 8; // Lines that may be requested but not yet filled.

	logic miss;
	logic req_accepted;
	logic fill_done;
	logic writeback;
	shader_front_pkg::line_addr_t miss_line;
	shader_front_pkg::fill_t fill;
	shader_front_pkg::wave_t wave;
	shader_front_pkg::insn_t held_insn;

	icache_lookup lookup (
		.clk,
		.rst_n,
		.icache_flush,
		.read_valid,
		.read_pc,
		.read_group,
		.fill,
		.fill_done,
		.req_accepted,
		.miss,
		.miss_line,
		.wave
	);

	icache_refill #(
		.PENDING_DEPTH(PENDING_DEPTH)
	) refill (
		.clk,
		.rst_n,
		.miss,
		.miss_line,
		.mem_req_valid,
		.mem_req_ready,
		.mem_req_line,
		.mem_beat_valid,
		.mem_beat_data,
		.mem_beat_last,
		.mem_beat_ready,
		.req_accepted,
		.fill,
		.fill_done
	);

	class_dispatch class_stage (
		.clk,
		.rst_n,
		.wave,
		.dispatch,
		.out_group,
		.held_insn,
		.writeback
	);

	fpint_decode fpint_dec (
		.clk,
		.insn(held_insn),
		.writeback,
		.op(fpint_op)
	);

endmodule

`default_nettype wire

// ==== logic/shader_front_pkg.sv ====
`default_nettype none

package shader_front_pkg;

	localparam int LINE_BITS = 5;
	localparam int WORD_BITS = 3;
	localparam int PC_BITS = 30;
	localparam int GROUP_BITS = 6;
	localparam int NUM_LINES = 1 << LINE_BITS;
	localparam int LINE_WORDS = 1 << WORD_BITS;
	localparam int TAG_BITS = PC_BITS - LINE_BITS - WORD_BITS;

	typedef logic [31:0] word_t;
	typedef logic [GROUP_BITS-1:0] group_id_t;
	typedef logic [LINE_BITS-1:0] line_num_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [WORD_BITS-1:0] word_num_t;

	typedef struct packed {
		tag_t      tag;
		line_num_t line;
	} line_addr_t;

	typedef struct packed {
		line_addr_t line_addr;
		word_num_t  word_num;
	} pc_t;

	typedef enum logic [1:0] {
		INSN_FPINT,
		INSN_MEM,
		INSN_SFU,
		INSN_GROUP
	} insn_class_e;

	typedef enum logic [2:0] {
		FPINT_MOV,
		FPINT_FMUL,
		FPINT_IMUL,
		FPINT_FADD,
		FPINT_FMAX,
		FPINT_FMIN,
		FPINT_FCVT
	} fpint_opcode_e;

	typedef struct packed {
		insn_class_e   insn_class;
		fpint_opcode_e fpint_op;
		logic [26:0]   payload; // Operands, decoded further down the core.
	} insn_t;

	typedef struct packed {
		logic      valid;
		logic      retry;
		group_id_t group;
		insn_t     insn;
	} wave_t;

	typedef struct packed {
		logic valid;
		logic p1_mem;
		logic p2_sfu;
		logic p3_group;
	} dispatch_t;

	typedef struct packed {
		logic setup_mul_float;
		logic setup_unit_b;
		logic mnorm_put_hi;
		logic mnorm_put_lo;
		logic mnorm_put_mul;
		logic mnorm_zero_flags;
		logic mnorm_zero_b;
		logic minmax_abs;
		logic minmax_swap;
		logic minmax_zero_min;
		logic minmax_copy_flags;
		logic shiftr_int_signed;
		logic addsub_int_operand;
		logic addsub_copy_flags;
		logic clz_force_nop;
		logic shiftl_copy_flags;
		logic round_copy_flags;
		logic round_enable;
		logic encode_enable;
		logic writeback;
	} fpint_op_t;

	typedef struct packed {
		logic                   enable;
		line_num_t              line;
		tag_t                   tag;
		word_t [LINE_WORDS-1:0] data; // Word 0 is the first beat.
	} fill_t;

endpackage

`default_nettype wire

// ==== sim/shader_front_golden.txt ====
// Image A at 00 and image B at 20, one instruction word per entry, eight words per line.
// Reads at 40 as {group, pc}; fpint flag vectors without writeback at 50, by opcode.
@00
00000011 08000022 10000033 18000044 20000055 28000066 30000077 40000088
80000101 C0000102 40000103 18000104 80000105 C0000106 28000107 20000108
40000201 08000202 80000203 C0000204 30000205 40000206 00000207 80000208
C0000301 10000302 40000303 80000304 18000305 C0000306 20000307 28000308
@20
80000411 40000422 C0000433 30000444 08000455 80000466 40000477 28000488
00000511 80000512 C0000513 40000514 20000515 10000516 80000517 C0000518
C0000611 28000612 40000613 80000614 00000615 C0000616 18000617 40000618
30000711 C0000712 80000713 08000714 40000715 20000716 C0000717 10000718
@40
0100000003 020000000A 0300000015 040000001E 0500000000 0600000007 0700000009 080000000C
090000000F 0A00000010 0B00000011 0C00000013 0D00000018 0E0000001B 0F0000001C 1000000006
@50
2B93F 4593F 0B93C 28803 2833C 2873C 2B8E3

// ==== sim/shader_front_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module shader_front_tb;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_READS = 16;
	localparam int RESULT_DELAY = 8;
	localparam int MAX_ATTEMPTS = 40;
	localparam int RETRY_GAP = 10;
	localparam int READ_BASE = 'h40;
	localparam int FLAG_BASE = 'h50;
	localparam int WATCHDOG_CYCLES = NUM_READS * 200;

	typedef struct packed {
		int                          due;
		logic                        img;
		shader_front_pkg::pc_t       pc;
		shader_front_pkg::group_id_t group;
	} expect_t;

	logic clk;
	logic rst_n;
	logic read_valid;
	shader_front_pkg::pc_t read_pc;
	shader_front_pkg::group_id_t read_group;
	logic icache_flush;
	logic mem_req_valid;
	logic mem_req_ready;
	shader_front_pkg::line_addr_t mem_req_line;
	logic mem_beat_valid;
	shader_front_pkg::word_t mem_beat_data;
	logic mem_beat_last;
	logic mem_beat_ready;
	shader_front_pkg::dispatch_t dispatch;
	shader_front_pkg::group_id_t out_group;
	shader_front_pkg::fpint_op_t fpint_op;

	logic [63:0] golden [0:127];
	expect_t exp_q [$];
	shader_front_pkg::line_addr_t out_q [$]; // Lines requested and not yet fully returned.
	integer seed = 32'h5730_bdc1;
	int cycle_count = 0;
	int done_count = 0;
	int errors = 0;
	int checks = 0;
	int retries = 0;
	int fpint_checked = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors = 0;
	int wait_cnt = 0;
	logic [2:0] beat_idx = '0;
	logic [3:0] class_seen = '0;
	logic last_retry = 1'b1;
	logic mem_img = 1'b0;
	logic bp_mode = 1'b0;

	shader_front dut_i (
		.clk,
		.rst_n,
		.read_valid,
		.read_pc,
		.read_group,
		.icache_flush,
		.mem_req_valid,
		.mem_req_ready,
		.mem_req_line,
		.mem_beat_valid,
		.mem_beat_data,
		.mem_beat_last,
		.mem_beat_ready,
		.dispatch,
		.out_group,
		.fpint_op
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// Both images hold four lines, so only tag 0 and lines 0 to 3 exist.
	function automatic shader_front_pkg::word_t image_word(input logic img,
		input shader_front_pkg::line_addr_t la, input logic [2:0] w);
		logic [5:0] idx;
		idx = {img, la.line[1:0], w};
		return golden[idx][31:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic compare_result();
		expect_t e;
		shader_front_pkg::word_t w;
		logic retry;
		logic [1:0] cls;
		logic [19:0] exp_op;
		if (exp_q.size() != 0 && exp_q[0].due == cycle_count) begin
			e = exp_q.pop_front();
			w = image_word(e.img, e.pc.line_addr, e.pc.word_num);
			retry = ~(dispatch.p1_mem | dispatch.p2_sfu | dispatch.p3_group | fpint_op.writeback);
			check_value("dispatch.valid", 32'd1, 32'(dispatch.valid));
			check_value("out_group", 32'(e.group), 32'(out_group));
			if (!retry) begin
				cls = w[31:30];
				check_value("dispatch.p1_mem", 32'(cls == 2'd1), 32'(dispatch.p1_mem));
				check_value("dispatch.p2_sfu", 32'(cls == 2'd2), 32'(dispatch.p2_sfu));
				check_value("dispatch.p3_group", 32'(cls == 2'd3), 32'(dispatch.p3_group));
				if (cls == 2'd0) begin
					exp_op = {golden[FLAG_BASE + int'(w[29:27])][18:0], 1'b1};
					check_value("fpint_op", 32'(exp_op), 32'(fpint_op));
					fpint_checked++;
				end else begin
					check_value("fpint_op.writeback", 32'd0, 32'(fpint_op.writeback));
				end
				class_seen[cls] = 1'b1;
			end else begin
				retries++;
			end
			last_retry = retry;
			done_count++;
		end else if (dispatch.valid) begin
			errors++;
			$display("Dispatch raised at %0t ns with no read due", $time);
		end
	endtask

	// Outputs change only on the rising edge, so the falling edge sees them settled.
	initial begin
		forever begin
			@(negedge clk);
			if (rst_n)
				compare_result();
		end
	end

	task automatic memory_tick();
		mem_beat_valid = 1'b0;
		mem_beat_last = 1'b0;
		if (out_q.size() != 0) begin
			if (wait_cnt != 0) begin
				wait_cnt--;
			end else begin
				mem_beat_valid = ($random(seed) & 3) != 0;
				mem_beat_data = image_word(mem_img, out_q[0], beat_idx);
				mem_beat_last = beat_idx == 3'd7;
				if (mem_beat_valid && mem_beat_ready) begin
					if (beat_idx == 3'd7) begin
						out_q.delete(0);
						wait_cnt = $random(seed) & 7;
					end
					beat_idx = beat_idx + 3'd1;
				end
			end
		end
		mem_req_ready = bp_mode ? (($random(seed) & 1) != 0) : 1'b1;
		if (mem_req_valid && mem_req_ready) begin
			if (mem_req_line.tag != '0 || mem_req_line.line >= 5'd4) begin
				errors++;
				$display("Request at %0t ns for line %h outside the memory image", $time,
					mem_req_line);
			end
			foreach (out_q[i]) begin
				if (out_q[i] == mem_req_line) begin
					errors++;
					$display("Line %h requested again while outstanding", mem_req_line);
				end
			end
			if (out_q.size() == 0)
				wait_cnt = $random(seed) & 7;
			out_q.push_back(mem_req_line);
		end
	endtask

	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (rst_n)
				memory_tick();
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
		read_valid = 1'b0;
	endtask

	task automatic drive_read(input shader_front_pkg::pc_t pc, input shader_front_pkg::group_id_t grp,
		input logic img);
		expect_t e;
		read_valid = 1'b1;
		read_pc = pc;
		read_group = grp;
		e.due = cycle_count + RESULT_DELAY;
		e.img = img;
		e.pc = pc;
		e.group = grp;
		exp_q.push_back(e);
	endtask

	task automatic wait_results(input int target);
		while (done_count < target)
			next_cycle();
	endtask

	task automatic read_until_hit(input shader_front_pkg::pc_t pc,
		input shader_front_pkg::group_id_t grp, input logic img, input logic expect_miss);
		int attempts;
		attempts = 0;
		last_retry = 1'b1;
		while (last_retry && attempts < MAX_ATTEMPTS) begin
			drive_read(pc, grp, img);
			next_cycle();
			wait_results(done_count + 1);
			if (attempts == 0 && expect_miss && !last_retry) begin
				errors++;
				$display("First read of pc %h hit on a cold line", pc);
			end
			attempts++;
			if (last_retry)
				repeat (RETRY_GAP) next_cycle();
		end
		if (last_retry) begin
			errors++;
			$display("Read of pc %h still retried after %0d attempts", pc, attempts);
		end
	endtask

	task automatic read_entry(input int idx, input logic img, input logic expect_miss);
		read_until_hit(golden[READ_BASE + idx][29:0], golden[READ_BASE + idx][37:32], img,
			expect_miss);
	endtask

	task automatic pulse_flush();
		icache_flush = 1'b1;
		next_cycle();
		next_cycle();
		icache_flush = 1'b0;
		repeat (32) next_cycle();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors > test_start_errors) begin
			tests_failed++;
			$display("Test %s: failed", name);
		end else begin
			$display("Test %s: passed", name);
		end
		test_start_errors = errors;
	endtask

	initial begin
		int snap;
		rst_n = 1'b0;
		read_valid = 1'b0;
		read_pc = '0;
		read_group = '0;
		icache_flush = 1'b0;
		mem_req_ready = 1'b0;
		mem_beat_valid = 1'b0;
		mem_beat_data = '0;
		mem_beat_last = 1'b0;
		$readmemh("sim/shader_front_golden.txt", golden);
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value("mem_req_valid", 32'd0, 32'(mem_req_valid));
		check_value("mem_beat_ready", 32'd0, 32'(mem_beat_ready));
		check_value("dispatch", 32'd0, 32'(dispatch));
		repeat (40) next_cycle();

		for (int i = 0; i < 4; i++)
			read_entry(i, 1'b0, 1'b1);
		finish_test("cold miss then hit");

		class_seen = '0;
		for (int i = 4; i < NUM_READS; i++)
			read_entry(i, 1'b0, 1'b0);
		if (class_seen != 4'hf) begin
			errors++;
			$display("Not every instruction class reached its port");
		end
		finish_test("class dispatch");

		snap = fpint_checked;
		for (int op = 0; op < 7; op++)
			read_until_hit(30'(op), 6'(op + 32), 1'b0, 1'b0); // Line 0 holds the opcodes in order.
		if (fpint_checked - snap != 7) begin
			errors++;
			$display("Only %0d of 7 opcodes were decoded", fpint_checked - snap);
		end
		finish_test("fpint decode");

		snap = retries;
		for (int w = 0; w < 8; w++) begin
			drive_read(30'(8 + w), 6'(20 + w), 1'b0);
			next_cycle();
		end
		wait_results(done_count + exp_q.size());
		if (retries != snap) begin
			errors++;
			$display("Back-to-back reads of a resident line returned a retry");
		end
		finish_test("back-to-back reads");

		mem_img = 1'b1;
		pulse_flush();
		for (int i = 0; i < 4; i++)
			read_entry(i, 1'b1, 1'b1);
		for (int i = 4; i < NUM_READS; i++)
			read_entry(i, 1'b1, 1'b0);
		finish_test("flush");

		mem_img = 1'b0;
		bp_mode = 1'b1;
		pulse_flush();
		// These reads hit lines 0, 1 and 2 in runs of two or three.
		for (int i = 4; i < 12; i++) begin
			drive_read(golden[READ_BASE + i][29:0], golden[READ_BASE + i][37:32], 1'b0);
			next_cycle();
		end
		wait_results(done_count + exp_q.size());
		for (int i = 0; i < NUM_READS; i++)
			read_entry(i, 1'b0, 1'b0);
		bp_mode = 1'b0;
		finish_test("memory back-pressure");

		repeat (10) next_cycle();
		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d", tests_run,
			tests_failed, checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/shader_front_pkg.sv
logic/line_fifo.sv
logic/icache_refill.sv
logic/icache_lookup.sv
logic/class_dispatch.sv
logic/fpint_decode.sv
logic/shader_front.sv
sim/shader_front_tb.sv
